//--- include/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath and address width
`define CPU_XLEN 16
`define CPU_NREG 16
`define CPU_RIDX 4
`define CPU_PC_STEP 16'd2

// instruction fields
`define CPU_F_OP 15:12
`define CPU_F_RD 11:8
`define CPU_F_RS 7:4
`define CPU_F_RT 3:0
`define CPU_F_COND 11:9
`define CPU_F_OFF 8:0

// bubble word, ADD R0,R0,R0
`define CPU_NOP 16'h0000

`endif

//--- hdl/cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

	// major opcodes, the gaps decode as no-ops
	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_XOR = 4'h2,
		OP_SLL = 4'h4,
		OP_LW  = 4'h8,
		OP_SW  = 4'h9,
		OP_LHB = 4'hA,
		OP_LLB = 4'hB,
		OP_B   = 4'hC,
		OP_HLT = 4'hF
	} opcode_e;

	// branch condition field, instr[11:9]
	typedef enum logic [2:0] {
		C_NEQ,
		C_EQ,
		C_GT,
		C_LT,
		C_GTE,
		C_LTE,
		C_OVF,
		C_UNCOND
	} cond_e;

	typedef struct packed {
		logic z;
		logic v;
		logic n;
	} flags_t;

	typedef struct packed {
		logic                 taken;
		logic [`CPU_XLEN-1:0] target;
	} redirect_t;

	typedef struct packed {
		logic                 valid;
		logic [`CPU_XLEN-1:0] pc;
		logic [`CPU_XLEN-1:0] instr;
	} ifid_t;

	// rs/rt keep the raw fields, LHB/LLB take their byte from them
	typedef struct packed {
		logic                 valid;
		opcode_e              op;
		logic [`CPU_RIDX-1:0] rd;
		logic [`CPU_RIDX-1:0] rs;
		logic [`CPU_RIDX-1:0] rt;
		logic [`CPU_XLEN-1:0] opa;
		logic [`CPU_XLEN-1:0] opb;
		logic [3:0]           imm;
		logic                 wr;
		logic                 ld;
	} idex_t;

	typedef struct packed {
		logic                 valid;
		opcode_e              op;
		logic [`CPU_RIDX-1:0] rd;
		logic [`CPU_XLEN-1:0] result;
		logic [`CPU_XLEN-1:0] sdata;
		logic                 wr;
	} exmem_t;

	typedef struct packed {
		logic                 we;
		logic [`CPU_RIDX-1:0] rd;
		logic [`CPU_XLEN-1:0] data;
	} wb_t;

	typedef struct packed {
		logic                 valid;
		logic                 write;
		logic [`CPU_XLEN-1:0] addr;
		logic [`CPU_XLEN-1:0] wdata;
	} dmem_req_t;

endpackage

//--- hdl/cpu_alu.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_alu (
	input  cpu_pkg::opcode_e     op,
	input  logic [`CPU_XLEN-1:0] a,
	input  logic [`CPU_XLEN-1:0] b,
	input  logic [3:0]           imm,
	output logic [`CPU_XLEN-1:0] result,
	input  cpu_pkg::flags_t      flags_in,
	output cpu_pkg::flags_t      flags
);

	logic [`CPU_XLEN-1:0] sum;
	logic [`CPU_XLEN-1:0] diff;
	logic [`CPU_XLEN-1:0] sat;
	logic                 add_ovf;
	logic                 sub_ovf;

	assign sum  = a + b;
	assign diff = a - b;
	// signed overflow, result sign disagrees with the operands
	assign add_ovf = (a[`CPU_XLEN-1] == b[`CPU_XLEN-1]) & (sum[`CPU_XLEN-1] != a[`CPU_XLEN-1]);
	assign sub_ovf = (a[`CPU_XLEN-1] != b[`CPU_XLEN-1]) & (diff[`CPU_XLEN-1] != a[`CPU_XLEN-1]);
	// clamp toward a's sign, 8000 or 7fff
	assign sat = {a[`CPU_XLEN-1], {(`CPU_XLEN-1){~a[`CPU_XLEN-1]}}};

	always_comb begin
		result = sum;
		flags  = flags_in;
		case (op)
			cpu_pkg::OP_ADD: begin
				result  = add_ovf ? sat : sum;
				flags.v = add_ovf;
				flags.n = result[`CPU_XLEN-1];
			end
			cpu_pkg::OP_SUB: begin
				result  = sub_ovf ? sat : diff;
				flags.v = sub_ovf;
				flags.n = result[`CPU_XLEN-1];
			end
			// logical ops leave V and N alone
			cpu_pkg::OP_XOR: result = a ^ b;
			cpu_pkg::OP_SLL: result = a << imm;
			cpu_pkg::OP_LHB: result = {b[7:0], a[7:0]};
			cpu_pkg::OP_LLB: result = {a[15:8], b[7:0]};
			// LW/SW address
			default: result = sum;
		endcase
		flags.z = (result == '0);
	end

endmodule

//--- hdl/cpu_fetch.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_fetch (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 hold,
	input  logic                 stall,
	input  cpu_pkg::redirect_t   redirect,
	output logic [`CPU_XLEN-1:0] pc,
	input  logic [`CPU_XLEN-1:0] instr,
	output cpu_pkg::ifid_t       ifid
);

	logic [`CPU_XLEN-1:0] pc_seq;
	logic [`CPU_XLEN-1:0] pc_next;
	logic                 advance;

	// sequential address, halfword steps
	assign pc_seq = pc + `CPU_PC_STEP;
	// load-use, halt and memory back-pressure all freeze fetch
	assign advance = ~hold & ~stall;
	assign pc_next = redirect.taken ? redirect.target : pc_seq;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (advance) begin
			pc <= pc_next;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ifid.valid <= 1'b0;
		end else if (advance) begin
			// taken redirect squashes the word fetched this cycle
			ifid.valid <= ~redirect.taken;
			ifid.pc    <= pc;
			ifid.instr <= redirect.taken ? `CPU_NOP : instr;
		end
	end

endmodule

//--- hdl/cpu_decode.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_decode (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 stall,
	input  cpu_pkg::ifid_t       ifid,
	input  cpu_pkg::flags_t      ex_flags,
	output logic [`CPU_RIDX-1:0] rd1,
	output logic [`CPU_RIDX-1:0] rd2,
	input  logic [`CPU_XLEN-1:0] rdata1,
	input  logic [`CPU_XLEN-1:0] rdata2,
	output cpu_pkg::idex_t       idex,
	output cpu_pkg::redirect_t   redirect,
	output logic                 hold
);

	cpu_pkg::opcode_e     op;
	cpu_pkg::cond_e       cond;
	cpu_pkg::idex_t       idex_d;
	logic [`CPU_RIDX-1:0] f_rd;
	logic [`CPU_RIDX-1:0] f_rs;
	logic [`CPU_RIDX-1:0] f_rt;
	logic [8:0]           off;
	logic [`CPU_XLEN-1:0] br_target;
	logic                 known;
	logic                 writes;
	logic                 use_a;
	logic                 use_b;
	logic                 cond_met;
	logic                 is_br;
	logic                 is_hlt;
	logic                 hlt_first;
	logic                 load_use;
	logic                 halted;

	assign op   = cpu_pkg::opcode_e'(ifid.instr[`CPU_F_OP]);
	assign cond = cpu_pkg::cond_e'(ifid.instr[`CPU_F_COND]);
	assign f_rd = ifid.instr[`CPU_F_RD];
	assign f_rs = ifid.instr[`CPU_F_RS];
	assign f_rt = ifid.instr[`CPU_F_RT];
	assign off  = ifid.instr[`CPU_F_OFF];

	// port 1 reads rd for the byte loads, port 2 reads rd for stores
	assign rd1 = (op == cpu_pkg::OP_LHB || op == cpu_pkg::OP_LLB) ? f_rd : f_rs;
	assign rd2 = (op == cpu_pkg::OP_SW) ? f_rd : f_rt;

	// opcode classes
	always_comb begin
		known  = 1'b1;
		writes = 1'b0;
		use_a  = 1'b0;
		use_b  = 1'b0;
		case (op)
			cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_XOR: begin
				writes = 1'b1;
				use_a  = 1'b1;
				use_b  = 1'b1;
			end
			cpu_pkg::OP_SLL, cpu_pkg::OP_LW, cpu_pkg::OP_LHB, cpu_pkg::OP_LLB: begin
				writes = 1'b1;
				use_a  = 1'b1;
			end
			cpu_pkg::OP_SW: begin
				use_a = 1'b1;
				use_b = 1'b1;
			end
			cpu_pkg::OP_B, cpu_pkg::OP_HLT: known = 1'b1;
			default: known = 1'b0;
		endcase
	end

	// flags come bypassed from execute, the instruction just ahead
	always_comb begin
		case (cond)
			cpu_pkg::C_NEQ: cond_met = ~ex_flags.z;
			cpu_pkg::C_EQ:  cond_met = ex_flags.z;
			cpu_pkg::C_GT:  cond_met = ~ex_flags.z & ~ex_flags.n;
			cpu_pkg::C_LT:  cond_met = ex_flags.n;
			cpu_pkg::C_GTE: cond_met = ex_flags.z | ~ex_flags.n;
			cpu_pkg::C_LTE: cond_met = ex_flags.z | ex_flags.n;
			cpu_pkg::C_OVF: cond_met = ex_flags.v;
			default:        cond_met = 1'b1;
		endcase
	end

	// target is pc+2 plus word offset
	assign br_target = ifid.pc + `CPU_PC_STEP + {{(`CPU_XLEN-10){off[8]}}, off, 1'b0};
	assign is_br     = ifid.valid & (op == cpu_pkg::OP_B);
	assign is_hlt    = ifid.valid & (op == cpu_pkg::OP_HLT);
	assign hlt_first = is_hlt & ~halted;

	// load in execute feeding this instruction, one bubble
	assign load_use = ifid.valid & idex.valid & idex.ld & idex.wr &
		((use_a & (rd1 == idex.rd)) | (use_b & (rd2 == idex.rd)));

	// first sight of HLT pulls pc back onto the HLT itself
	assign redirect.taken  = (is_br & cond_met & ~halted) | hlt_first;
	assign redirect.target = hlt_first ? ifid.pc : br_target;
	assign hold            = load_use | halted;

	always_comb begin
		idex_d.valid = ifid.valid & known & ~load_use & ~halted;
		idex_d.op    = op;
		idex_d.rd    = f_rd;
		idex_d.rs    = f_rs;
		idex_d.rt    = f_rt;
		idex_d.opa   = rdata1;
		idex_d.opb   = rdata2;
		idex_d.imm   = f_rt;
		// R0 never written, so never forwarded
		idex_d.wr    = idex_d.valid & writes & (f_rd != '0);
		idex_d.ld    = (op == cpu_pkg::OP_LW);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idex.valid <= 1'b0;
			idex.wr    <= 1'b0;
			halted     <= 1'b0;
		end else if (!stall) begin
			idex <= idex_d;
			if (hlt_first) begin
				halted <= 1'b1;
			end
		end
	end

endmodule

//--- hdl/cpu_regfile.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_regfile (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [`CPU_RIDX-1:0] rd1,
	input  logic [`CPU_RIDX-1:0] rd2,
	output logic [`CPU_XLEN-1:0] rdata1,
	output logic [`CPU_XLEN-1:0] rdata2,
	input  cpu_pkg::wb_t         wb
);

	logic [`CPU_XLEN-1:0] regs [`CPU_NREG];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `CPU_NREG; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.we && wb.rd != '0) begin
			regs[wb.rd] <= wb.data;
		end
	end

	// R0 hardwired, writeback in the same cycle is visible to decode
	assign rdata1 = (rd1 == '0) ? '0 : (wb.we && wb.rd == rd1) ? wb.data : regs[rd1];
	assign rdata2 = (rd2 == '0) ? '0 : (wb.we && wb.rd == rd2) ? wb.data : regs[rd2];

endmodule

//--- hdl/cpu_execute.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_execute (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             stall,
	input  cpu_pkg::idex_t   idex,
	input  cpu_pkg::exmem_t  mem_fwd,
	input  cpu_pkg::wb_t     wb,
	output cpu_pkg::flags_t  flags_next,
	output cpu_pkg::exmem_t  exmem
);

	logic [`CPU_RIDX-1:0] src_a;
	logic [`CPU_RIDX-1:0] src_b;
	logic [`CPU_XLEN-1:0] fwd_a;
	logic [`CPU_XLEN-1:0] fwd_b;
	logic [`CPU_XLEN-1:0] alu_a;
	logic [`CPU_XLEN-1:0] alu_b;
	logic [`CPU_XLEN-1:0] alu_y;
	logic                 is_mem;
	logic                 is_byte;
	logic                 sets_flags;
	cpu_pkg::flags_t      flags_q;
	cpu_pkg::flags_t      alu_flags;

	// memory stage wins over writeback, loads there are covered by the stall
	function automatic logic [`CPU_XLEN-1:0] fwd_sel(
		input logic [`CPU_RIDX-1:0] src,
		input logic [`CPU_XLEN-1:0] regval,
		input cpu_pkg::exmem_t      m,
		input cpu_pkg::wb_t         w
	);
		if (m.wr && m.op != cpu_pkg::OP_LW && m.rd == src) begin
			return m.result;
		end
		if (w.we && w.rd == src) begin
			return w.data;
		end
		return regval;
	endfunction

	assign is_mem  = (idex.op == cpu_pkg::OP_LW) || (idex.op == cpu_pkg::OP_SW);
	assign is_byte = (idex.op == cpu_pkg::OP_LHB) || (idex.op == cpu_pkg::OP_LLB);
	assign src_a   = is_byte ? idex.rd : idex.rs;
	assign src_b   = (idex.op == cpu_pkg::OP_SW) ? idex.rd : idex.rt;
	assign fwd_a   = fwd_sel(src_a, idex.opa, mem_fwd, wb);
	assign fwd_b   = fwd_sel(src_b, idex.opb, mem_fwd, wb);

	// base is halfword aligned, offset counts halfwords
	assign alu_a = is_mem ? {fwd_a[`CPU_XLEN-1:1], 1'b0} : fwd_a;
	assign alu_b = is_mem ? {{(`CPU_XLEN-5){idex.imm[3]}}, idex.imm, 1'b0} :
		is_byte ? {8'h00, idex.rs, idex.rt} : fwd_b;

	cpu_alu u_alu (
		.op       (idex.op),
		.a        (alu_a),
		.b        (alu_b),
		.imm      (idex.imm),
		.result   (alu_y),
		.flags_in (flags_q),
		.flags    (alu_flags)
	);

	assign sets_flags = idex.valid && (idex.op == cpu_pkg::OP_ADD ||
		idex.op == cpu_pkg::OP_SUB || idex.op == cpu_pkg::OP_XOR || idex.op == cpu_pkg::OP_SLL);
	// decode resolves branches against this
	assign flags_next = sets_flags ? alu_flags : flags_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			flags_q     <= '0;
			exmem.valid <= 1'b0;
			exmem.wr    <= 1'b0;
		end else if (!stall) begin
			flags_q      <= flags_next;
			exmem.valid  <= idex.valid;
			exmem.op     <= idex.op;
			exmem.rd     <= idex.rd;
			exmem.result <= alu_y;
			// store data is rd, already forwarded
			exmem.sdata  <= fwd_b;
			exmem.wr     <= idex.wr;
		end
	end

endmodule

//--- hdl/cpu_memory.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_memory (
	input  logic                 clk,
	input  logic                 rst_n,
	input  cpu_pkg::exmem_t      exmem,
	output cpu_pkg::dmem_req_t   dmem_req,
	input  logic                 dmem_ready,
	input  logic [`CPU_XLEN-1:0] dmem_rdata,
	output logic                 stall,
	output cpu_pkg::wb_t         wb,
	output logic                 hlt
);

	logic is_ld;
	logic is_st;
	logic is_hlt;

	assign is_ld  = exmem.valid & (exmem.op == cpu_pkg::OP_LW);
	assign is_st  = exmem.valid & (exmem.op == cpu_pkg::OP_SW);
	assign is_hlt = exmem.valid & (exmem.op == cpu_pkg::OP_HLT);

	// request straight off the EX/MEM register, stable while frozen
	assign dmem_req.valid = is_ld | is_st;
	assign dmem_req.write = is_st;
	assign dmem_req.addr  = exmem.result;
	assign dmem_req.wdata = exmem.sdata;

	// waiting on ready freezes every stage
	assign stall = dmem_req.valid & ~dmem_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb.we <= 1'b0;
			hlt   <= 1'b0;
		end else if (!stall) begin
			wb.we   <= exmem.wr;
			wb.rd   <= exmem.rd;
			// read data sampled in the completing cycle
			wb.data <= is_ld ? dmem_rdata : exmem.result;
			// sticky until reset
			if (is_hlt) begin
				hlt <= 1'b1;
			end
		end
	end

endmodule

//--- hdl/cpu.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu (
	input  logic                 clk,
	input  logic                 rst_n,
	output logic [`CPU_XLEN-1:0] pc,
	input  logic [`CPU_XLEN-1:0] instr,
	output logic                 hlt,
	output cpu_pkg::dmem_req_t   dmem_req,
	input  logic                 dmem_ready,
	input  logic [`CPU_XLEN-1:0] dmem_rdata
);

	cpu_pkg::redirect_t   redirect;
	cpu_pkg::ifid_t       ifid;
	cpu_pkg::idex_t       idex;
	cpu_pkg::exmem_t      exmem;
	cpu_pkg::wb_t         wb;
	cpu_pkg::flags_t      flags_next;
	logic                 hold;
	logic                 stall;
	logic [`CPU_RIDX-1:0] rd1;
	logic [`CPU_RIDX-1:0] rd2;
	logic [`CPU_XLEN-1:0] rdata1;
	logic [`CPU_XLEN-1:0] rdata2;

	cpu_fetch u_fetch (
		.clk(clk), .rst_n(rst_n), .hold(hold), .stall(stall),
		.redirect(redirect), .pc(pc), .instr(instr), .ifid(ifid)
	);

	cpu_decode u_decode (
		.clk(clk), .rst_n(rst_n), .stall(stall), .ifid(ifid), .ex_flags(flags_next),
		.rd1(rd1), .rd2(rd2), .rdata1(rdata1), .rdata2(rdata2),
		.idex(idex), .redirect(redirect), .hold(hold)
	);

	cpu_regfile u_regfile (
		.clk(clk), .rst_n(rst_n), .rd1(rd1), .rd2(rd2),
		.rdata1(rdata1), .rdata2(rdata2), .wb(wb)
	);

	// exmem loops back as the memory-stage forwarding source
	cpu_execute u_execute (
		.clk(clk), .rst_n(rst_n), .stall(stall), .idex(idex), .mem_fwd(exmem),
		.wb(wb), .flags_next(flags_next), .exmem(exmem)
	);

	cpu_memory u_memory (
		.clk(clk), .rst_n(rst_n), .exmem(exmem), .dmem_req(dmem_req),
		.dmem_ready(dmem_ready), .dmem_rdata(dmem_rdata),
		.stall(stall), .wb(wb), .hlt(hlt)
	);

endmodule

//--- tb/cpu_properties.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_properties (
	input logic                 clk,
	input logic                 rst_n,
	input logic [`CPU_XLEN-1:0] pc,
	input logic                 hlt,
	input cpu_pkg::dmem_req_t   dmem_req,
	input logic                 dmem_ready
);

	// state right after a reset cycle
	assert property (@(posedge clk) !rst_n |=> (pc == '0 && !hlt && !dmem_req.valid))
	else $error("reset state wrong");

	// request frozen while waiting on ready
	assert property (@(posedge clk) disable iff (!rst_n)
		dmem_req.valid && !dmem_ready |=> $stable(dmem_req))
	else $error("dmem request changed while waiting");

	// halt is sticky and pc parks
	assert property (@(posedge clk) disable iff (!rst_n) hlt |=> hlt && $stable(pc))
	else $error("hlt dropped or pc moved after halt");

	assert property (@(posedge clk) disable iff (!rst_n) hlt |-> !dmem_req.valid)
	else $error("request after halt");

endmodule

bind cpu cpu_properties u_props (
	.clk(clk), .rst_n(rst_n), .pc(pc), .hlt(hlt),
	.dmem_req(dmem_req), .dmem_ready(dmem_ready)
);

//--- tb/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_tb;

	localparam int NPROG = 20;
	localparam int NRAND = 30;
	// 400 cycles of 4 ns per program
	localparam int LIMIT_NS = NPROG * 400 * 4;

	logic                 clk;
	logic                 rst_n;
	logic [`CPU_XLEN-1:0] pc;
	logic [`CPU_XLEN-1:0] instr;
	logic                 hlt;
	logic                 dmem_ready;
	logic [`CPU_XLEN-1:0] dmem_rdata;
	cpu_pkg::dmem_req_t   dmem_req;

	logic [31:0]          lfsr;
	logic [15:0]          imem [128];
	logic [15:0]          dmem [512];
	logic [15:0]          mmem [512];
	logic [15:0]          mregs [16];
	logic [15:0]          exp_addr [$];
	logic [15:0]          exp_data [$];
	logic [15:0]          hlt_pc;

	cpu u_cpu (
		.clk(clk), .rst_n(rst_n), .pc(pc), .instr(instr), .hlt(hlt),
		.dmem_req(dmem_req), .dmem_ready(dmem_ready), .dmem_rdata(dmem_rdata)
	);

	// both memories answer in the same cycle
	assign instr      = imem[pc[7:1]];
	assign dmem_rdata = dmem[dmem_req.addr[9:1]];

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[14:0], fb};
		end
		return r;
	endfunction

	task automatic report_mismatch(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		$display("Errors found");
		$fatal(1, "value mismatch");
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "check failed");
	endtask

	// R1 stays the load/store base, random writers use R2..R15
	function automatic logic [15:0] random_instr();
		logic [15:0] t;
		logic [2:0]  sel;
		logic [3:0]  rd;
		logic [3:0]  rs;
		logic [3:0]  rt;
		t   = rand_bits(15);
		sel = t[2:0];
		rd  = t[6:3];
		rs  = t[10:7];
		rt  = t[14:11];
		if (rd < 4'd2) begin
			rd = rd + 4'd2;
		end
		case (sel)
			3'd0: return {4'h0, rd, rs, rt};
			3'd1: return {4'h1, rd, rs, rt};
			3'd2: return {4'h2, rd, rs, rt};
			3'd3: return {4'h4, rd, rs, rt};
			3'd4: return {4'h8, rd, 4'd1, rt};
			3'd5: return {4'h9, rs, 4'd1, rt};
			// forward only, at most four words ahead
			3'd6: return {4'hC, rt[2:0], 7'd0, rs[1:0]};
			default: return {rt[0] ? 4'hA : 4'hB, rd, rs, rt};
		endcase
	endfunction

	task automatic build_program();
		int          k;
		logic [15:0] v;
		for (int i = 0; i < 128; i++) begin
			imem[i] = `CPU_NOP;
		end
		k = 0;
		for (int r = 1; r < 16; r++) begin
			v = (r == 1) ? 16'h0120 : rand_bits(16);
			imem[k]     = {4'hB, 4'(r), v[7:0]};
			imem[k + 1] = {4'hA, 4'(r), v[15:8]};
			k = k + 2;
		end
		for (int i = 0; i < NRAND; i++) begin
			imem[k] = random_instr();
			k = k + 1;
		end
		// base 0x210, stores land at 0x200..0x21c
		imem[k]     = {4'hB, 4'd1, 8'h10};
		imem[k + 1] = {4'hA, 4'd1, 8'h02};
		k = k + 2;
		for (int r = 2; r < 16; r++) begin
			imem[k] = {4'h9, 4'(r), 4'd1, 4'(r - 10)};
			k = k + 1;
		end
		imem[k]     = {4'h9, 4'd1, 4'd1, 4'd6};
		imem[k + 1] = 16'hF000;
	endtask

	function automatic logic cond_true(input logic [2:0] c, input logic z, input logic v,
		input logic n);
		case (c)
			3'd0: return !z;
			3'd1: return z;
			3'd2: return !z && !n;
			3'd3: return n;
			3'd4: return z || !n;
			3'd5: return z || n;
			3'd6: return v;
			default: return 1'b1;
		endcase
	endfunction

	// sequential ISA model, fills the expected store queue
	task automatic run_model();
		logic [15:0] mpc;
		logic [15:0] w;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		logic [15:0] addr;
		logic        z;
		logic        v;
		logic        n;
		int          s;
		int          steps;
		for (int r = 0; r < 16; r++) begin
			mregs[r] = '0;
		end
		z = 1'b0;
		v = 1'b0;
		n = 1'b0;
		mpc = '0;
		steps = 0;
		exp_addr.delete();
		exp_data.delete();
		while (imem[mpc[7:1]][15:12] != 4'hF && steps < 500) begin
			w    = imem[mpc[7:1]];
			a    = mregs[w[7:4]];
			b    = mregs[w[3:0]];
			addr = {a[15:1], 1'b0} + {{11{w[3]}}, w[3:0], 1'b0};
			mpc  = mpc + 16'd2;
			case (w[15:12])
				4'h0, 4'h1: begin
					if (w[15:12] == 4'h0) begin
						s = int'($signed(a)) + int'($signed(b));
					end else begin
						s = int'($signed(a)) - int'($signed(b));
					end
					v = (s > 32767) || (s < -32768);
					if (s > 32767) begin
						s = 32767;
					end else if (s < -32768) begin
						s = -32768;
					end
					res = s[15:0];
					z = (res == 16'd0);
					n = res[15];
					mregs[w[11:8]] = res;
				end
				4'h2, 4'h4: begin
					res = (w[15:12] == 4'h2) ? (a ^ b) : (a << w[3:0]);
					z = (res == 16'd0);
					mregs[w[11:8]] = res;
				end
				4'h8: mregs[w[11:8]] = mmem[addr[9:1]];
				4'h9: begin
					mmem[addr[9:1]] = mregs[w[11:8]];
					exp_addr.push_back(addr);
					exp_data.push_back(mregs[w[11:8]]);
				end
				4'hA: mregs[w[11:8]] = {w[7:0], mregs[w[11:8]][7:0]};
				4'hB: mregs[w[11:8]] = {mregs[w[11:8]][15:8], w[7:0]};
				4'hC: begin
					if (cond_true(w[11:9], z, v, n)) begin
						mpc = mpc + {{6{w[8]}}, w[8:0], 1'b0};
					end
				end
				default: ;
			endcase
			mregs[0] = '0;
			steps = steps + 1;
		end
		hlt_pc = mpc;
	endtask

	// completed stores against the model, in order
	always @(posedge clk) begin
		if (rst_n && dmem_req.valid && dmem_ready && dmem_req.write) begin
			assert (exp_addr.size() > 0)
			else report_failure("store seen after the expected sequence ended");
			assert (dmem_req.addr == exp_addr[0] && dmem_req.wdata == exp_data[0])
			else report_mismatch($sformatf("store %h<-%h, expected %h<-%h",
				dmem_req.addr, dmem_req.wdata, exp_addr[0], exp_data[0]));
			void'(exp_addr.pop_front());
			void'(exp_data.pop_front());
			dmem[dmem_req.addr[9:1]] <= dmem_req.wdata;
		end
	end

	initial begin
		#(LIMIT_NS);
		$display("Errors found");
		$fatal(1, "timeout, a program never reached HLT");
	end

	initial begin
		logic [15:0] t;
		rst_n      = 1'b0;
		dmem_ready = 1'b0;
		lfsr       = 32'hbc22;
		for (int i = 0; i < 128; i++) begin
			imem[i] = `CPU_NOP;
		end
		for (int p = 0; p < NPROG; p++) begin
			@(posedge clk);
			#1;
			rst_n      = 1'b0;
			dmem_ready = 1'b0;
			build_program();
			for (int i = 0; i < 512; i++) begin
				t = rand_bits(16);
				dmem[i] = t;
				mmem[i] = t;
			end
			run_model();
			@(posedge clk);
			@(posedge clk);
			#1;
			assert (pc == '0 && !hlt && !dmem_req.valid)
			else report_mismatch($sformatf("reset state pc=%h hlt=%b", pc, hlt));
			rst_n = 1'b1;
			while (!hlt) begin
				// ready high three cycles in four
				t = rand_bits(2);
				dmem_ready = (t[1:0] != 2'd0);
				@(posedge clk);
				#1;
			end
			assert (exp_addr.size() == 0)
			else report_failure("halted before all expected stores were made");
			assert (pc == hlt_pc)
			else report_mismatch($sformatf("halt pc %h, expected %h", pc, hlt_pc));
			repeat (3) begin
				@(posedge clk);
				#1;
				assert (!dmem_req.valid)
				else report_failure("memory request issued after halt");
			end
		end
		$display("No errors");
		$finish;
	end

endmodule

//--- sim.f
+incdir+include
hdl/cpu_pkg.sv
hdl/cpu_alu.sv
hdl/cpu_fetch.sv
hdl/cpu_decode.sv
hdl/cpu_regfile.sv
hdl/cpu_execute.sv
hdl/cpu_memory.sv
hdl/cpu.sv
tb/cpu_properties.sv
tb/cpu_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module cpu_tb -o sim_cpu

out=$(./obj_dir/sim_cpu)
echo "$out"

if echo "$out" | grep -q "No errors"; then
	exit 0
else
	exit 1
fi
